//--- build.f
src/ecc_pkg.sv
src/mod_mul.sv
src/mod_inv.sv
src/field_alu.sv
src/point_sequencer.sv
src/key_scanner.sv
src/ecc_scalar_mult_top.sv
verification/tb_ecc_scalar_mult.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f build.f \
    --top-module tb_ecc_scalar_mult -Mdir obj_dir -o sim_tb

output=$(./obj_dir/sim_tb 2>&1 || true)
echo "$output"

if echo "$output" | grep -q "TESTBENCH PASSED"; then
    exit 0
else
    exit 1
fi

//--- verification/tb_ecc_scalar_mult.sv
`timescale 1ns/10ps

module tb_ecc_scalar_mult;

    localparam int          FIELD_WIDTH = 32;
    localparam int          KEY_WIDTH   = 16;
    localparam logic [63:0] PRIME       = 64'd2147483647;
    localparam logic [63:0] CURVE_A     = 64'd2;
    localparam int          RANDOM_RUNS = 16;
    localparam int          CYCLE_LIMIT = 20 * 16 * 21 * 70;

    logic                   clk_p_i;
    logic                   reset_n_i;
    logic                   start;
    logic [KEY_WIDTH-1:0]   key;
    logic [FIELD_WIDTH-1:0] px;
    logic [FIELD_WIDTH-1:0] py;
    logic [FIELD_WIDTH-1:0] prime;
    logic [FIELD_WIDTH-1:0] curve_a;
    logic                   busy;
    logic                   done;
    logic [FIELD_WIDTH-1:0] qx;
    logic [FIELD_WIDTH-1:0] qy;

    logic [63:0] exp_qx      = '0;
    logic [63:0] exp_qy      = '0;
    logic        expect_done = 1'b0;
    int          done_count  = 0;
    int          runs_started = 0;
    int          cycle_count = 0;

    ecc_scalar_mult_top #(
        .FIELD_WIDTH(FIELD_WIDTH),
        .KEY_WIDTH  (KEY_WIDTH)
    ) UUT (
        .clk_p_i  (clk_p_i),
        .reset_n_i(reset_n_i),
        .start    (start),
        .key      (key),
        .px       (px),
        .py       (py),
        .prime    (prime),
        .curve_a  (curve_a),
        .busy     (busy),
        .done     (done),
        .qx       (qx),
        .qy       (qy)
    );

    initial
    begin
        clk_p_i = 1'b0;
        forever #10 clk_p_i = ~clk_p_i;
    end

    function automatic logic [63:0] mul_mod(input logic [63:0] a, input logic [63:0] b);
        return (a * b) % PRIME; // operands below 2^31
    endfunction

    function automatic logic [63:0] add_mod(input logic [63:0] a, input logic [63:0] b);
        return (a + b) % PRIME;
    endfunction

    function automatic logic [63:0] sub_mod(input logic [63:0] a, input logic [63:0] b);
        return (a + PRIME - b) % PRIME;
    endfunction

    // fermat inverse v^(p-2)
    function automatic logic [63:0] inv_mod(input logic [63:0] v);
        logic [63:0] base;
        logic [63:0] acc;
        logic [63:0] e;
        base = v;
        acc  = 64'd1;
        e    = PRIME - 64'd2;
        while (e != 64'd0)
        begin
            if (e[0])
                acc = mul_mod(acc, base);
            base = mul_mod(base, base);
            e    = e >> 1;
        end
        return acc;
    endfunction

    // double-and-add from the bit below the top
    function automatic logic expected_mult(input logic [KEY_WIDTH-1:0] k,
                                           input logic [63:0] bx, input logic [63:0] by,
                                           output logic [63:0] rx, output logic [63:0] ry);
        logic [63:0] x;
        logic [63:0] y;
        logic [63:0] sq;
        logic [63:0] num;
        logic [63:0] den;
        logic [63:0] lam;
        logic [63:0] x3;
        logic        ok;
        int          i;
        ok = 1'b1;
        x  = bx;
        y  = by;
        for (i = KEY_WIDTH - 2; i >= 0; i--)
        begin
            sq  = mul_mod(x, x);
            num = add_mod(add_mod(add_mod(sq, sq), sq), CURVE_A);
            den = add_mod(y, y);
            if (den == 64'd0)
                ok = 1'b0;
            lam = mul_mod(num, inv_mod(den));
            x3  = sub_mod(sub_mod(mul_mod(lam, lam), x), x);
            y   = sub_mod(mul_mod(lam, sub_mod(x, x3)), y);
            x   = x3;
            if (k[i])
            begin
                den = sub_mod(bx, x);
                if (den == 64'd0)
                    ok = 1'b0;
                lam = mul_mod(sub_mod(by, y), inv_mod(den));
                x3  = sub_mod(sub_mod(mul_mod(lam, lam), x), bx);
                y   = sub_mod(mul_mod(lam, sub_mod(x, x3)), y);
                x   = x3;
            end
        end
        rx = x;
        ry = y;
        return ok; // low when a denominator was zero
    endfunction

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] want);
        if (got !== want)
        begin
            $display("FAIL %s: got 0x%0h expected 0x%0h", name, got, want);
            $display("TESTBENCH FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // redraws the point until no denominator hits zero
    task automatic draw_point(input logic [KEY_WIDTH-1:0] k, output logic [63:0] x,
                              output logic [63:0] y, output logic [63:0] ex,
                              output logic [63:0] ey);
        logic ok;
        ok = 1'b0;
        while (!ok)
        begin
            x  = 64'($urandom) % PRIME;
            y  = 64'($urandom) % PRIME;
            ok = expected_mult(k, x, y, ex, ey);
        end
    endtask

    task automatic start_mult(input logic [KEY_WIDTH-1:0] k, input logic [63:0] x,
                              input logic [63:0] y, input logic [63:0] ex,
                              input logic [63:0] ey);
        exp_qx      = ex;
        exp_qy      = ey;
        expect_done = 1'b1;
        runs_started++;
        @(posedge clk_p_i);
        start <= 1'b1;
        key   <= k;
        px    <= x[FIELD_WIDTH-1:0];
        py    <= y[FIELD_WIDTH-1:0];
        @(posedge clk_p_i);
        start <= 1'b0;
        @(negedge clk_p_i);
        compare_value("busy", 64'(busy), 64'd1); // rises the cycle after start
    endtask

    task automatic wait_result();
        while (done_count < runs_started)
            @(posedge clk_p_i);
        expect_done = 1'b0;
    endtask

    always @(posedge clk_p_i)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT)
        begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TESTBENCH FAILED");
            $fatal(1, "simulation timed out");
        end
    end

    // outputs are settled at the falling edge
    always @(negedge clk_p_i)
    begin
        if (reset_n_i && done)
        begin
            compare_value("done", 64'(done), 64'(expect_done));
            compare_value("busy", 64'(busy), 64'd0); // falls together with done
            compare_value("qx", 64'(qx), exp_qx);
            compare_value("qy", 64'(qy), exp_qy);
            done_count = done_count + 1;
        end
    end

    initial
    begin
        logic [KEY_WIDTH-1:0] k;
        logic [63:0]          x;
        logic [63:0]          y;
        logic [63:0]          ex;
        logic [63:0]          ey;
        int                   n;
        void'($urandom(32'hcc39));
        reset_n_i <= 1'b0;
        start     <= 1'b0;
        key       <= '0;
        px        <= '0;
        py        <= '0;
        prime     <= PRIME[FIELD_WIDTH-1:0];
        curve_a   <= CURVE_A[FIELD_WIDTH-1:0];
        repeat (5) @(posedge clk_p_i);
        reset_n_i <= 1'b1;
        @(negedge clk_p_i);
        compare_value("busy", 64'(busy), 64'd0);
        compare_value("done", 64'(done), 64'd0);
        compare_value("qx", 64'(qx), 64'd0);
        compare_value("qy", 64'(qy), 64'd0);

        k = 16'h8000; // doublings only
        draw_point(k, x, y, ex, ey);
        start_mult(k, x, y, ex, ey);
        wait_result();

        k = 16'hffff; // add on every bit
        draw_point(k, x, y, ex, ey);
        start_mult(k, x, y, ex, ey);
        wait_result();

        for (n = 0; n < RANDOM_RUNS; n++)
        begin
            k = 16'($urandom) | 16'h8000;
            draw_point(k, x, y, ex, ey);
            start_mult(k, x, y, ex, ey);
            wait_result();
        end

        // second start in the middle of a run
        k = 16'($urandom) | 16'h8000;
        draw_point(k, x, y, ex, ey);
        start_mult(k, x, y, ex, ey);
        repeat (40) @(posedge clk_p_i);
        start <= 1'b1;
        key   <= ~k;
        px    <= FIELD_WIDTH'($urandom % 32'h7fffffff);
        py    <= FIELD_WIDTH'($urandom % 32'h7fffffff);
        @(posedge clk_p_i);
        start <= 1'b0;
        wait_result();

        repeat (60)
        begin
            @(negedge clk_p_i);
            compare_value("busy", 64'(busy), 64'd0);
            compare_value("qx", 64'(qx), ex); // result of the accepted run
            compare_value("qy", 64'(qy), ey);
        end

        k = 16'($urandom) | 16'h8000;
        draw_point(k, x, y, ex, ey);
        start_mult(k, x, y, ex, ey);
        wait_result();

        repeat (5) @(posedge clk_p_i);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- src/ecc_scalar_mult_top.sv
`timescale 1ns/10ps

module ecc_scalar_mult_top #(
    parameter int FIELD_WIDTH = ecc_pkg::DEFAULT_FIELD_WIDTH,
    parameter int KEY_WIDTH   = ecc_pkg::DEFAULT_KEY_WIDTH
) (
    input  logic                   clk_p_i,
    input  logic                   reset_n_i,
    input  logic                   start,
    input  logic [KEY_WIDTH-1:0]   key,
    input  logic [FIELD_WIDTH-1:0] px,
    input  logic [FIELD_WIDTH-1:0] py,
    input  logic [FIELD_WIDTH-1:0] prime,
    input  logic [FIELD_WIDTH-1:0] curve_a,
    output logic                   busy,
    output logic                   done,
    output logic [FIELD_WIDTH-1:0] qx,
    output logic [FIELD_WIDTH-1:0] qy
);

    import ecc_pkg::*;

    logic                   load;
    logic                   point_start;
    logic                   add_bit;
    logic                   point_done;
    logic                   op_start;
    logic                   op_done;
    field_op_e              op;
    logic [FIELD_WIDTH-1:0] operand_a;
    logic [FIELD_WIDTH-1:0] operand_b;
    logic [FIELD_WIDTH-1:0] result;

    key_scanner #(
        .KEY_WIDTH(KEY_WIDTH)
    ) u_key_scanner (
        .clk_p_i    (clk_p_i),
        .reset_n_i  (reset_n_i),
        .start      (start),
        .key        (key),
        .point_done (point_done),
        .load       (load),
        .point_start(point_start),
        .add_bit    (add_bit),
        .busy       (busy),
        .done       (done)
    );

    point_sequencer #(
        .FIELD_WIDTH(FIELD_WIDTH)
    ) u_point_sequencer (
        .clk_p_i    (clk_p_i),
        .reset_n_i  (reset_n_i),
        .load       (load),
        .point_start(point_start),
        .add_bit    (add_bit),
        .px         (px),
        .py         (py),
        .curve_a    (curve_a),
        .op_done    (op_done),
        .result     (result),
        .point_done (point_done),
        .op_start   (op_start),
        .op         (op),
        .operand_a  (operand_a),
        .operand_b  (operand_b),
        .qx         (qx),
        .qy         (qy)
    );

    field_alu #(
        .FIELD_WIDTH(FIELD_WIDTH)
    ) u_field_alu (
        .clk_p_i  (clk_p_i),
        .reset_n_i(reset_n_i),
        .op_start (op_start),
        .op       (op),
        .operand_a(operand_a),
        .operand_b(operand_b),
        .prime    (prime),
        .op_done  (op_done),
        .result   (result)
    );

endmodule

//--- src/key_scanner.sv
`timescale 1ns/10ps

module key_scanner #(
    parameter int KEY_WIDTH = ecc_pkg::DEFAULT_KEY_WIDTH
) (
    input  logic                 clk_p_i,
    input  logic                 reset_n_i,
    input  logic                 start,
    input  logic [KEY_WIDTH-1:0] key,
    input  logic                 point_done,
    output logic                 load,
    output logic                 point_start,
    output logic                 add_bit,
    output logic                 busy,
    output logic                 done
);

    localparam int CNT_W = $clog2(KEY_WIDTH);

    logic [KEY_WIDTH-1:0] key_sh;
    logic [CNT_W-1:0]     bits_left;

    assign load    = start && !busy; // start while busy is dropped
    assign add_bit = key_sh[KEY_WIDTH-1];

    always_ff @(posedge clk_p_i or negedge reset_n_i)
    begin
        if (!reset_n_i)
        begin
            key_sh      <= '0;
            bits_left   <= '0;
            busy        <= 1'b0;
            done        <= 1'b0;
            point_start <= 1'b0;
        end
        else
        begin
            done        <= 1'b0;
            point_start <= 1'b0;
            if (load)
            begin
                key_sh      <= {key[KEY_WIDTH-2:0], 1'b0}; // top bit is P itself
                bits_left   <= CNT_W'(KEY_WIDTH - 1);
                busy        <= 1'b1;
                point_start <= 1'b1;
            end
            else if (busy && point_done)
            begin
                if (bits_left == CNT_W'(1))
                begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
                else
                begin
                    key_sh      <= {key_sh[KEY_WIDTH-2:0], 1'b0};
                    bits_left   <= bits_left - 1'b1;
                    point_start <= 1'b1;
                end
            end
        end
    end

endmodule

//--- src/point_sequencer.sv
`timescale 1ns/10ps

module point_sequencer #(
    parameter int FIELD_WIDTH = ecc_pkg::DEFAULT_FIELD_WIDTH
) (
    input  logic                   clk_p_i,
    input  logic                   reset_n_i,
    input  logic                   load,
    input  logic                   point_start,
    input  logic                   add_bit,
    input  logic [FIELD_WIDTH-1:0] px,
    input  logic [FIELD_WIDTH-1:0] py,
    input  logic [FIELD_WIDTH-1:0] curve_a,
    input  logic                   op_done,
    input  logic [FIELD_WIDTH-1:0] result,
    output logic                   point_done,
    output logic                   op_start,
    output ecc_pkg::field_op_e     op,
    output logic [FIELD_WIDTH-1:0] operand_a,
    output logic [FIELD_WIDTH-1:0] operand_b,
    output logic [FIELD_WIDTH-1:0] qx,
    output logic [FIELD_WIDTH-1:0] qy
);

    import ecc_pkg::*;

    localparam logic [2:0] SRC_X1 = 3'd0; // accumulator
    localparam logic [2:0] SRC_Y1 = 3'd1;
    localparam logic [2:0] SRC_X2 = 3'd2; // base point
    localparam logic [2:0] SRC_Y2 = 3'd3;
    localparam logic [2:0] SRC_R1 = 3'd4;
    localparam logic [2:0] SRC_R2 = 3'd5;
    localparam logic [2:0] SRC_A  = 3'd6;
    localparam logic       DST_R1 = 1'b0;
    localparam logic       DST_R2 = 1'b1;

    localparam logic [4:0] DBL_X3   = 5'd9;
    localparam logic [4:0] DBL_LAST = 5'd12;
    localparam logic [4:0] ADD_X3   = 5'd18;
    localparam logic [4:0] ADD_LAST = 5'd21;

    logic [4:0]             step;
    logic                   add_r;
    logic [8:0]             uop;
    logic [FIELD_WIDTH-1:0] x1;
    logic [FIELD_WIDTH-1:0] y1;
    logic [FIELD_WIDTH-1:0] x2;
    logic [FIELD_WIDTH-1:0] y2;
    logic [FIELD_WIDTH-1:0] r1;
    logic [FIELD_WIDTH-1:0] r2;
    logic [FIELD_WIDTH-1:0] x3;
    logic [FIELD_WIDTH-1:0] curve_a_r;

    // {op, src a, src b, dest}
    always_comb
    begin
        case (step)
            5'd1:    uop = {FIELD_MUL, SRC_X1, SRC_X1, DST_R1}; // x^2
            5'd2:    uop = {FIELD_ADD, SRC_R1, SRC_R1, DST_R2};
            5'd3:    uop = {FIELD_ADD, SRC_R1, SRC_R2, DST_R1}; // 3x^2
            5'd4:    uop = {FIELD_ADD, SRC_R1, SRC_A,  DST_R1};
            5'd5:    uop = {FIELD_ADD, SRC_Y1, SRC_Y1, DST_R2}; // 2y
            5'd6:    uop = {FIELD_DIV, SRC_R1, SRC_R2, DST_R1}; // lambda
            5'd7:    uop = {FIELD_MUL, SRC_R1, SRC_R1, DST_R2};
            5'd8:    uop = {FIELD_SUB, SRC_R2, SRC_X1, DST_R2};
            5'd9:    uop = {FIELD_SUB, SRC_R2, SRC_X1, DST_R2}; // x3
            5'd10:   uop = {FIELD_SUB, SRC_X1, SRC_R2, DST_R2};
            5'd11:   uop = {FIELD_MUL, SRC_R1, SRC_R2, DST_R1};
            5'd12:   uop = {FIELD_SUB, SRC_R1, SRC_Y1, DST_R1}; // y3
            5'd13:   uop = {FIELD_SUB, SRC_X2, SRC_X1, DST_R1};
            5'd14:   uop = {FIELD_SUB, SRC_Y2, SRC_Y1, DST_R2};
            5'd15:   uop = {FIELD_DIV, SRC_R2, SRC_R1, DST_R1}; // lambda
            5'd16:   uop = {FIELD_MUL, SRC_R1, SRC_R1, DST_R2};
            5'd17:   uop = {FIELD_SUB, SRC_R2, SRC_X1, DST_R2};
            5'd18:   uop = {FIELD_SUB, SRC_R2, SRC_X2, DST_R2}; // x3
            5'd19:   uop = {FIELD_SUB, SRC_X1, SRC_R2, DST_R2};
            5'd20:   uop = {FIELD_MUL, SRC_R1, SRC_R2, DST_R2};
            5'd21:   uop = {FIELD_SUB, SRC_R2, SRC_Y1, DST_R2}; // y3
            default: uop = {FIELD_ADD, SRC_X1, SRC_X1, DST_R1};
        endcase
    end

    always_comb
    begin
        case (uop[6:4])
            SRC_X1:  operand_a = x1;
            SRC_Y1:  operand_a = y1;
            SRC_X2:  operand_a = x2;
            SRC_Y2:  operand_a = y2;
            SRC_R1:  operand_a = r1;
            SRC_R2:  operand_a = r2;
            default: operand_a = curve_a_r;
        endcase
        case (uop[3:1])
            SRC_X1:  operand_b = x1;
            SRC_Y1:  operand_b = y1;
            SRC_X2:  operand_b = x2;
            SRC_Y2:  operand_b = y2;
            SRC_R1:  operand_b = r1;
            SRC_R2:  operand_b = r2;
            default: operand_b = curve_a_r;
        endcase
    end

    assign op = field_op_e'(uop[8:7]);

    always_ff @(posedge clk_p_i or negedge reset_n_i)
    begin
        if (!reset_n_i)
        begin
            step       <= '0;
            add_r      <= 1'b0;
            op_start   <= 1'b0;
            point_done <= 1'b0;
        end
        else
        begin
            op_start   <= 1'b0;
            point_done <= 1'b0;
            if (step == '0)
            begin
                if (point_start)
                begin
                    step     <= 5'd1;
                    add_r    <= add_bit;
                    op_start <= 1'b1;
                end
            end
            else if (op_done)
            begin
                if ((step == DBL_LAST && !add_r) || step == ADD_LAST)
                begin
                    step       <= '0;
                    point_done <= 1'b1;
                end
                else
                begin
                    step     <= step + 5'd1; // doubling runs on into the add
                    op_start <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_p_i or negedge reset_n_i)
    begin
        if (!reset_n_i)
        begin
            x1 <= '0;
            y1 <= '0;
        end
        else if (load)
        begin
            x1 <= px;
            y1 <= py;
        end
        else if (op_done && (step == DBL_LAST || step == ADD_LAST))
        begin
            x1 <= x3;
            y1 <= result;
        end
    end

    always_ff @(posedge clk_p_i)
    begin
        if (load)
        begin
            x2        <= px;
            y2        <= py;
            curve_a_r <= curve_a;
        end
        if (op_done)
        begin
            if (uop[0] == DST_R2)
                r2 <= result;
            else
                r1 <= result;
            if (step == DBL_X3 || step == ADD_X3)
                x3 <= result;
        end
    end

    assign qx = x1;
    assign qy = y1;

endmodule

//--- src/field_alu.sv
`timescale 1ns/10ps

module field_alu #(
    parameter int FIELD_WIDTH = ecc_pkg::DEFAULT_FIELD_WIDTH
) (
    input  logic                   clk_p_i,
    input  logic                   reset_n_i,
    input  logic                   op_start,
    input  ecc_pkg::field_op_e     op,
    input  logic [FIELD_WIDTH-1:0] operand_a,
    input  logic [FIELD_WIDTH-1:0] operand_b,
    input  logic [FIELD_WIDTH-1:0] prime,
    output logic                   op_done,
    output logic [FIELD_WIDTH-1:0] result
);

    import ecc_pkg::*;

    logic [FIELD_WIDTH-1:0] sum;
    logic [FIELD_WIDTH-1:0] diff;
    logic [FIELD_WIDTH-1:0] addsub_result;
    logic                   addsub_done;
    logic                   div_phase;
    logic                   mul_start;
    logic                   mul_done;
    logic                   inv_start;
    logic                   inv_done;
    logic [FIELD_WIDTH-1:0] mul_b;
    logic [FIELD_WIDTH-1:0] product;
    logic [FIELD_WIDTH-1:0] inverse;

    assign sum       = operand_a + operand_b;
    assign diff      = operand_a - operand_b; // wraps, fixed up with +p
    assign inv_start = op_start && (op == FIELD_DIV);
    assign mul_start = (op_start && (op == FIELD_MUL)) || inv_done;
    assign mul_b     = div_phase ? inverse : operand_b;

    always_ff @(posedge clk_p_i or negedge reset_n_i)
    begin
        if (!reset_n_i)
        begin
            addsub_done <= 1'b0;
            div_phase   <= 1'b0;
        end
        else
        begin
            addsub_done <= op_start && ((op == FIELD_ADD) || (op == FIELD_SUB));
            if (inv_start)
                div_phase <= 1'b1; // invert b, then a * b^-1
            else if (mul_done)
                div_phase <= 1'b0;
        end
    end

    always_ff @(posedge clk_p_i)
    begin
        if (op_start)
        begin
            if (op == FIELD_SUB)
                addsub_result <= (operand_a >= operand_b) ? diff : diff + prime;
            else
                addsub_result <= (sum >= prime) ? sum - prime : sum;
        end
    end

    mod_mul #(
        .FIELD_WIDTH(FIELD_WIDTH)
    ) u_mod_mul (
        .clk_p_i  (clk_p_i),
        .reset_n_i(reset_n_i),
        .start    (mul_start),
        .a        (operand_a),
        .b        (mul_b),
        .prime    (prime),
        .done     (mul_done),
        .product  (product)
    );

    mod_inv #(
        .FIELD_WIDTH(FIELD_WIDTH)
    ) u_mod_inv (
        .clk_p_i  (clk_p_i),
        .reset_n_i(reset_n_i),
        .start    (inv_start),
        .value    (operand_b),
        .prime    (prime),
        .done     (inv_done),
        .inverse  (inverse)
    );

    assign op_done = addsub_done | mul_done;
    assign result  = mul_done ? product : addsub_result;

endmodule

//--- src/mod_inv.sv
`timescale 1ns/10ps

module mod_inv #(
    parameter int FIELD_WIDTH = ecc_pkg::DEFAULT_FIELD_WIDTH
) (
    input  logic                   clk_p_i,
    input  logic                   reset_n_i,
    input  logic                   start,
    input  logic [FIELD_WIDTH-1:0] value,
    input  logic [FIELD_WIDTH-1:0] prime,
    output logic                   done,
    output logic [FIELD_WIDTH-1:0] inverse
);

    logic [FIELD_WIDTH-1:0] u;
    logic [FIELD_WIDTH-1:0] v;
    logic [FIELD_WIDTH-1:0] x1;
    logic [FIELD_WIDTH-1:0] x2;
    logic                   running;
    logic                   finished;
    logic [FIELD_WIDTH-1:0] x1_half;
    logic [FIELD_WIDTH-1:0] x2_half;
    logic [FIELD_WIDTH-1:0] x1_sub;
    logic [FIELD_WIDTH-1:0] x2_sub;

    // halving mod p, add p first when odd
    always_comb
    begin
        x1_half  = (x1[0] ? x1 + prime : x1) >> 1;
        x2_half  = (x2[0] ? x2 + prime : x2) >> 1;
        x1_sub   = (x1 >= x2) ? x1 - x2 : x1 + (prime - x2);
        x2_sub   = (x2 >= x1) ? x2 - x1 : x2 + (prime - x1);
        finished = (u == FIELD_WIDTH'(1)) || (v == FIELD_WIDTH'(1));
    end

    always_ff @(posedge clk_p_i or negedge reset_n_i)
    begin
        if (!reset_n_i)
        begin
            running <= 1'b0;
            done    <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (start)
            begin
                running <= (value != '0);
                done    <= (value == '0); // zero maps to zero at once
            end
            else if (running && finished)
            begin
                running <= 1'b0;
                done    <= 1'b1;
            end
        end
    end

    // one reduction step per cycle
    always_ff @(posedge clk_p_i)
    begin
        if (start)
        begin
            u       <= value;
            v       <= prime;
            x1      <= FIELD_WIDTH'(1);
            x2      <= '0;
            inverse <= '0;
        end
        else if (running)
        begin
            if (u == FIELD_WIDTH'(1))
                inverse <= x1;
            else if (v == FIELD_WIDTH'(1))
                inverse <= x2;
            else if (!u[0])
            begin
                u  <= u >> 1;
                x1 <= x1_half;
            end
            else if (!v[0])
            begin
                v  <= v >> 1;
                x2 <= x2_half;
            end
            else if (u >= v)
            begin
                u  <= u - v;
                x1 <= x1_sub;
            end
            else
            begin
                v  <= v - u;
                x2 <= x2_sub;
            end
        end
    end

endmodule

//--- src/mod_mul.sv
`timescale 1ns/10ps

module mod_mul #(
    parameter int FIELD_WIDTH = ecc_pkg::DEFAULT_FIELD_WIDTH
) (
    input  logic                   clk_p_i,
    input  logic                   reset_n_i,
    input  logic                   start,
    input  logic [FIELD_WIDTH-1:0] a,
    input  logic [FIELD_WIDTH-1:0] b,
    input  logic [FIELD_WIDTH-1:0] prime,
    output logic                   done,
    output logic [FIELD_WIDTH-1:0] product
);

    localparam int CNT_W = $clog2(FIELD_WIDTH + 1);

    logic [FIELD_WIDTH-1:0] acc;
    logic [FIELD_WIDTH-1:0] b_sh;
    logic [CNT_W-1:0]       bits_left;
    logic                   running;
    logic [FIELD_WIDTH-1:0] dbl;
    logic [FIELD_WIDTH-1:0] dbl_red;
    logic [FIELD_WIDTH-1:0] sum;
    logic [FIELD_WIDTH-1:0] next_acc;

    // prime < 2^(W-1) so neither the doubling nor the add overflows
    always_comb
    begin
        dbl      = {acc[FIELD_WIDTH-2:0], 1'b0};
        dbl_red  = (dbl >= prime) ? dbl - prime : dbl;
        sum      = b_sh[FIELD_WIDTH-1] ? dbl_red + a : dbl_red;
        next_acc = (sum >= prime) ? sum - prime : sum;
    end

    always_ff @(posedge clk_p_i or negedge reset_n_i)
    begin
        if (!reset_n_i)
        begin
            running   <= 1'b0;
            bits_left <= '0;
            done      <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (start)
            begin
                running   <= 1'b1;
                bits_left <= CNT_W'(FIELD_WIDTH);
            end
            else if (running)
            begin
                bits_left <= bits_left - 1'b1;
                if (bits_left == CNT_W'(1))
                begin
                    running <= 1'b0;
                    done    <= 1'b1; // last bit of b consumed
                end
            end
        end
    end

    always_ff @(posedge clk_p_i)
    begin
        if (start)
        begin
            acc  <= '0;
            b_sh <= b;
        end
        else if (running)
        begin
            acc  <= next_acc;
            b_sh <= {b_sh[FIELD_WIDTH-2:0], 1'b0}; // msb first
        end
    end

    assign product = acc;

endmodule

//--- src/ecc_pkg.sv
package ecc_pkg;

    // opcode order matches the field unit decode
    typedef enum logic [1:0] {
        FIELD_ADD = 2'd0,
        FIELD_SUB = 2'd1,
        FIELD_MUL = 2'd2,
        FIELD_DIV = 2'd3
    } field_op_e;

    parameter int DEFAULT_FIELD_WIDTH = 32;
    parameter int DEFAULT_KEY_WIDTH   = 16;

endpackage
